//--- src/riscv_priv_pkg.sv
// ======================================================================
// RISC-V privilege architecture definitions.
// ======================================================================

package riscv_priv_pkg;

  // Privilege levels as encoded in mstatus.MPP and the core mode.
  // Value 2 is reserved by the spec.
  typedef enum logic [1:0] {
    priv_user       = 2'd0,
    priv_supervisor = 2'd1,
    priv_machine    = 2'd3
  } priv_mode_e;

  // ======================================================================
  // mstatus field positions.
  // ======================================================================

  // Modify privilege, loads and stores use MPP.
  localparam int mstatus_mprv_bit = 17;

  // Previous privilege, two bits wide.
  localparam int mstatus_mpp_lsb  = 11;

  // Supervisor may touch user pages.
  localparam int mstatus_sum_bit  = 18;

  // Make executable pages readable.
  localparam int mstatus_mxr_bit  = 19;

  // ======================================================================
  // satp field widths.
  // ======================================================================

  // Root page table PPN in Sv32 mode.
  localparam int satp_ppn_width   = 22;

endpackage

//--- src/sv32_pkg.sv
// ======================================================================
// Sv32 page table format and walker types.
// ======================================================================

package sv32_pkg;

  // PTE flag bits.
  localparam int pte_v_bit = 0;
  localparam int pte_r_bit = 1;
  localparam int pte_w_bit = 2;
  localparam int pte_x_bit = 3;
  localparam int pte_u_bit = 4;

  // PPN starts above the flags and RSW bits.
  localparam int pte_ppn_lsb    = 10;

  // PPN[0] must be zero for an aligned megapage.
  localparam int pte_ppn0_width = 10;

  // ======================================================================
  // Page geometry.
  // ======================================================================

  localparam int sv32_page_size         = 4096;
  localparam int sv32_page_offset_width = 12;

  // Each VPN level indexes 1024 entries.
  localparam int sv32_vpn_width         = 10;

  // Sv32 reaches a 34-bit physical space.
  localparam int phys_addr_width        = 34;

  // Size of one PTE in memory.
  localparam int pte_bytes              = 4;

  // ======================================================================
  // FSM states.
  // ======================================================================

  // Page table walker.
  typedef enum logic [1:0] {
    walk_idle,
    walk_read_l1,
    walk_read_l0,
    walk_done
  } walk_state_e;

  // Translation control.
  typedef enum logic {
    xlate_idle,
    xlate_check
  } xlate_state_e;

endpackage

//--- src/sv32_translate_data_to_physical.sv
`timescale 1ns/1ps

module sv32_translate_data_to_physical
  import riscv_priv_pkg::*, sv32_pkg::*;
(
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [31:0]                address,
  output logic [phys_addr_width-1:0] physical_address,
  input  logic                       is_write,
  output logic                       page_fault,
  input  logic [1:0]                 privilege_mode,
  input  logic [31:0]                mstatus,
  input  logic                       valid,
  output logic                       ready,
  output logic                       walk_valid,
  input  logic                       walk_ready,
  input  logic [31:0]                pte
);

  xlate_state_e state;
  xlate_state_e next_state;

  priv_mode_e eff_priv;
  logic [31:0] leaf;
  logic page_fault_nxt;
  logic ready_nxt;
  logic [phys_addr_width-1:0] physical_address_nxt;
  logic [sv32_page_offset_width-1:0] page_offset;

  // ======================================================================
  // State register.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= xlate_idle;
    end else begin
      state <= next_state;
    end
  end

  // Idle until the walker hands back an entry.
  // The check state always lasts one cycle.
  always_comb begin
    next_state = state;
    case (state)
      xlate_idle:  next_state = walk_ready ? xlate_check : xlate_idle;
      xlate_check: next_state = xlate_idle;
      default:     next_state = xlate_idle;
    endcase
  end

  // ======================================================================
  // Effective privilege.
  // ======================================================================

  // MPRV makes loads and stores act as MPP.
  always_comb begin
    if (mstatus[mstatus_mprv_bit]) begin
      eff_priv = priv_mode_e'(mstatus[mstatus_mpp_lsb +: 2]);
    end else begin
      eff_priv = priv_mode_e'(privilege_mode);
    end
  end

  // ======================================================================
  // Request handling and permission checks.
  // ======================================================================

  always_comb begin
    physical_address_nxt = physical_address;
    page_fault_nxt = page_fault;
    ready_nxt = 1'b0;
    walk_valid = 1'b0;
    leaf = pte;
    page_offset = sv32_page_offset_width'(address & (sv32_page_size - 1));

    case (state)
      xlate_idle: begin
        // Skip the ready cycle, the requester updates valid after it.
        if (valid && !ready) begin
          if (eff_priv == priv_machine) begin
            // No translation in machine mode.
            physical_address_nxt = {2'b00, address};
            page_fault_nxt = 1'b0;
            ready_nxt = 1'b1;
          end else begin
            walk_valid = 1'b1;
          end
        end
      end

      xlate_check: begin
        // MXR lets execute-only pages be read.
        if (mstatus[mstatus_mxr_bit] && pte[pte_x_bit]) begin
          leaf[pte_r_bit] = 1'b1;
        end

        page_fault_nxt = 1'b0;
        if (leaf[pte_w_bit] && !leaf[pte_r_bit]) begin
          // Reserved, write without read.
          page_fault_nxt = 1'b1;
        end else if (eff_priv == priv_supervisor) begin
          // User page needs SUM.
          if (leaf[pte_u_bit] && !mstatus[mstatus_sum_bit]) begin
            page_fault_nxt = 1'b1;
          end else if (is_write ? !leaf[pte_w_bit] : !leaf[pte_r_bit]) begin
            page_fault_nxt = 1'b1;
          end
        end else begin
          // User mode only sees U pages.
          if (!leaf[pte_u_bit]) begin
            page_fault_nxt = 1'b1;
          end else if (is_write ? !leaf[pte_w_bit] : !leaf[pte_r_bit]) begin
            page_fault_nxt = 1'b1;
          end
        end

        // Zero entries land here too and fault on R or W.
        if (page_fault_nxt) begin
          physical_address_nxt = '1;
        end else begin
          physical_address_nxt = {leaf[31:pte_ppn_lsb], page_offset};
        end
        ready_nxt = 1'b1;
      end

      default: ;
    endcase
  end

  // ======================================================================
  // Result registers.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready <= 1'b0;
      page_fault <= 1'b0;
      physical_address <= '0;
    end else begin
      ready <= ready_nxt;
      page_fault <= page_fault_nxt;
      physical_address <= physical_address_nxt;
    end
  end

endmodule

//--- src/sv32_table_walk.sv
`timescale 1ns/1ps

module sv32_table_walk
  import riscv_priv_pkg::*, sv32_pkg::*;
(
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [31:0]                address,
  input  logic [31:0]                satp,
  input  logic                       walk_valid,
  output logic                       walk_ready,
  output logic [31:0]                pte,
  output logic                       mem_valid,
  output logic [phys_addr_width-1:0] mem_addr,
  input  logic                       mem_ready,
  input  logic [31:0]                mem_rdata
);

  walk_state_e state;

  logic [sv32_vpn_width-1:0] vpn1;
  logic [sv32_vpn_width-1:0] vpn0;
  logic [phys_addr_width-1:0] l1_addr;
  logic [phys_addr_width-1:0] l0_addr;
  logic entry_invalid;
  logic entry_leaf;
  logic mega_misaligned;
  logic [31:0] mega_pte;
  logic accept;

  // ======================================================================
  // Address split and entry decode.
  // ======================================================================

  assign vpn1 = address[sv32_page_offset_width + sv32_vpn_width +: sv32_vpn_width];
  assign vpn0 = address[sv32_page_offset_width +: sv32_vpn_width];

  // Root table base comes from satp.
  assign l1_addr = {satp[satp_ppn_width-1:0], {sv32_page_offset_width{1'b0}}}
                 + phys_addr_width'(vpn1 * pte_bytes);

  // Second level base is the pointer entry's PPN.
  assign l0_addr = {mem_rdata[31:pte_ppn_lsb], {sv32_page_offset_width{1'b0}}}
                 + phys_addr_width'(vpn0 * pte_bytes);

  // V clear, or W without R.
  assign entry_invalid = !mem_rdata[pte_v_bit]
                       || (mem_rdata[pte_w_bit] && !mem_rdata[pte_r_bit]);

  // R or X marks a leaf, else a pointer.
  assign entry_leaf = mem_rdata[pte_r_bit] || mem_rdata[pte_x_bit];

  // Megapage needs PPN[0] of zero.
  assign mega_misaligned = |mem_rdata[pte_ppn_lsb +: pte_ppn0_width];

  // Fold VPN[0] into PPN[0] so the translator sees a 4 KiB mapping.
  always_comb begin
    mega_pte = mem_rdata;
    mega_pte[pte_ppn_lsb +: pte_ppn0_width] = vpn0;
  end

  // Ignore walk_valid in the cycle of our own ready pulse.
  assign accept = (state == walk_idle) && walk_valid && !walk_ready;

  // ======================================================================
  // Walk FSM.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= walk_idle;
      mem_valid <= 1'b0;
      walk_ready <= 1'b0;
    end else begin
      walk_ready <= 1'b0;
      case (state)
        walk_idle: begin
          if (accept) begin
            mem_valid <= 1'b1;
            state <= walk_read_l1;
          end
        end

        walk_read_l1: begin
          // Wait here for memory as long as it takes.
          if (mem_ready) begin
            if (entry_invalid || entry_leaf) begin
              mem_valid <= 1'b0;
              state <= walk_done;
            end else begin
              // Pointer, keep mem_valid up for level 0.
              state <= walk_read_l0;
            end
          end
        end

        walk_read_l0: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= walk_done;
          end
        end

        walk_done: begin
          walk_ready <= 1'b1;
          state <= walk_idle;
        end

        default: state <= walk_idle;
      endcase
    end
  end

  // ======================================================================
  // Memory address and result entry.
  // ======================================================================

  always_ff @(posedge clk) begin
    case (state)
      walk_idle: begin
        if (accept) begin
          mem_addr <= l1_addr;
        end
      end

      walk_read_l1: begin
        if (mem_ready) begin
          if (entry_invalid) begin
            pte <= '0;
          end else if (entry_leaf) begin
            pte <= mega_misaligned ? '0 : mega_pte;
          end else begin
            mem_addr <= l0_addr;
          end
        end
      end

      walk_read_l0: begin
        // Level 0 must end in a leaf.
        if (mem_ready) begin
          if (entry_invalid || !entry_leaf) begin
            pte <= '0;
          end else begin
            pte <= mem_rdata;
          end
        end
      end

      default: ;
    endcase
  end

endmodule

//--- src/sv32_data_mmu.sv
`timescale 1ns/1ps

module sv32_data_mmu
  import sv32_pkg::*;
(
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       valid,
  output logic                       ready,
  input  logic [31:0]                address,
  input  logic                       is_write,
  input  logic [1:0]                 privilege_mode,
  input  logic [31:0]                mstatus,
  input  logic [31:0]                satp,
  output logic [phys_addr_width-1:0] physical_address,
  output logic                       page_fault,
  output logic                       mem_valid,
  output logic [phys_addr_width-1:0] mem_addr,
  input  logic                       mem_ready,
  input  logic [31:0]                mem_rdata
);

  // ======================================================================
  // Translator to walker handshake.
  // ======================================================================

  logic walk_valid;
  logic walk_ready;
  logic [31:0] pte;

  // Privilege resolution and permission checks.
  sv32_translate_data_to_physical u_translate (
    .clk              (clk),
    .resetn           (resetn),
    .address          (address),
    .physical_address (physical_address),
    .is_write         (is_write),
    .page_fault       (page_fault),
    .privilege_mode   (privilege_mode),
    .mstatus          (mstatus),
    .valid            (valid),
    .ready            (ready),
    .walk_valid       (walk_valid),
    .walk_ready       (walk_ready),
    .pte              (pte)
  );

  // Two-level walk over the page-table memory port.
  sv32_table_walk u_table_walk (
    .clk        (clk),
    .resetn     (resetn),
    .address    (address),
    .satp       (satp),
    .walk_valid (walk_valid),
    .walk_ready (walk_ready),
    .pte        (pte),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic resetn
);

  // 20 ns period.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for a fixed count of rising edges, released on a falling edge.
  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
  end

endmodule

//--- test/tb_page_table_mem.sv
`timescale 1ns/1ps

module tb_page_table_mem (
  input  logic        clk,
  input  logic        resetn,
  input  logic        mem_valid,
  input  logic [33:0] mem_addr,
  output logic        mem_ready,
  output logic [31:0] mem_rdata
);

  localparam int depth = 4096;

  // Word storage, loaded by the testbench top before reset ends.
  logic [31:0] words [0:depth-1];

  logic        ready_r = 1'b0;
  logic [31:0] rdata_r = 32'h0;
  logic [31:0] rng = 32'd69;
  logic        pending = 1'b0;
  int          wait_left = 0;

  assign mem_ready = ready_r;
  assign mem_rdata = rdata_r;

  // 32-bit xorshift step.
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // ======================================================================
  // Response with a random delay of 0 to 3 cycles.
  // ======================================================================

  // Driven on the falling edge, the walker samples on the rising edge.
  always @(negedge clk) begin
    if (!resetn) begin
      ready_r <= 1'b0;
      pending = 1'b0;
      wait_left = 0;
    end else if (ready_r) begin
      // One-cycle pulse, the next request starts a cycle later.
      ready_r <= 1'b0;
    end else if (mem_valid) begin
      if (!pending) begin
        rng = xorshift32(rng);
        wait_left = int'(rng[1:0]);
        pending = 1'b1;
      end
      if (wait_left == 0) begin
        rdata_r <= words[mem_addr[13:2]];
        ready_r <= 1'b1;
        pending = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

endmodule

//--- test/tb_sv32_data_mmu.sv
`timescale 1ns/1ps

module tb_sv32_data_mmu
  import riscv_priv_pkg::*, sv32_pkg::*;
();

  localparam int reset_cycles = 16;
  localparam int total_requests = 31;
  localparam int cycle_limit = total_requests * 20 + reset_cycles;

  // Sv32 mode, root table in physical page 1.
  localparam logic [31:0] satp_root = 32'h8000_0001;
  localparam int root_word = 'h400;
  localparam int l0_word = 'h800;

  localparam logic [9:0] flag_v = 10'd1 << pte_v_bit;
  localparam logic [9:0] flag_r = 10'd1 << pte_r_bit;
  localparam logic [9:0] flag_w = 10'd1 << pte_w_bit;
  localparam logic [9:0] flag_x = 10'd1 << pte_x_bit;
  localparam logic [9:0] flag_u = 10'd1 << pte_u_bit;

  localparam logic [31:0] ms_mprv = 32'd1 << mstatus_mprv_bit;
  localparam logic [31:0] ms_sum = 32'd1 << mstatus_sum_bit;
  localparam logic [31:0] ms_mxr = 32'd1 << mstatus_mxr_bit;

  logic        clk;
  logic        resetn;
  logic        valid;
  logic        ready;
  logic [31:0] address;
  logic        is_write;
  logic [1:0]  privilege_mode;
  logic [31:0] mstatus;
  logic [31:0] satp;
  logic [33:0] physical_address;
  logic        page_fault;
  logic        mem_valid;
  logic [33:0] mem_addr;
  logic        mem_ready;
  logic [31:0] mem_rdata;

  logic [33:0] exp_pa;
  logic        exp_fault;
  logic        machine_access;
  int error_count = 0;
  int request_count = 0;
  int mark_errors = 0;
  int mark_requests = 0;
  int cycle_count = 0;

  tb_clock_gen #(.reset_cycles(reset_cycles)) u_clock (.clk(clk), .resetn(resetn));

  tb_page_table_mem u_mem (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  sv32_data_mmu DUT (
    .clk              (clk),
    .resetn           (resetn),
    .valid            (valid),
    .ready            (ready),
    .address          (address),
    .is_write         (is_write),
    .privilege_mode   (privilege_mode),
    .mstatus          (mstatus),
    .satp             (satp),
    .physical_address (physical_address),
    .page_fault       (page_fault),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_ready        (mem_ready),
    .mem_rdata        (mem_rdata)
  );

  // Request that should bypass translation.
  assign machine_access = (mstatus[mstatus_mprv_bit] ? mstatus[mstatus_mpp_lsb +: 2]
                                                     : privilege_mode) == priv_machine;

  // ======================================================================
  // Assertions.
  // ======================================================================

  address_check: assert property (@(posedge clk) disable iff (!resetn)
    ready |-> physical_address == exp_pa)
    else begin
      error_count = error_count + 1;
      $display("Fail physical_address expected 0x%09h got 0x%09h",
               exp_pa, $sampled(physical_address));
    end

  fault_check: assert property (@(posedge clk) disable iff (!resetn)
    ready |-> page_fault == exp_fault)
    else begin
      error_count = error_count + 1;
      $display("Fail page_fault expected 0x%0h got 0x%0h", exp_fault, $sampled(page_fault));
    end

  reset_check: assert property (@(posedge clk) $rose(resetn) |-> !ready && !mem_valid)
    else begin
      error_count = error_count + 1;
      $display("ready or mem_valid was high in the first cycle after reset");
    end

  // Accepted in idle, answered on the next edge.
  machine_latency_check: assert property (@(posedge clk) disable iff (!resetn)
    $past(valid && !ready && machine_access) |-> ready)
    else begin
      error_count = error_count + 1;
      $display("Machine-mode ready did not come one cycle after acceptance");
    end

  // Every table read is a word inside the 16 KiB table memory.
  mem_addr_check: assert property (@(posedge clk) disable iff (!resetn)
    mem_valid |-> mem_addr[33:14] == '0 && mem_addr[1:0] == 2'b00)
    else begin
      error_count = error_count + 1;
      $display("Page-table read at 0x%09h is outside the table or not word aligned",
               $sampled(mem_addr));
    end

  // Watchdog.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  // ======================================================================
  // Reference model.
  // ======================================================================

  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [9:0] flags);
    return {ppn, flags};
  endfunction

  // Two-level walk, returns the leaf with VPN[0] folded in, or zero.
  function automatic logic [31:0] reference_walk(input logic [31:0] va, input logic [31:0] root);
    logic [33:0] a;
    logic [31:0] e;
    a = {root[21:0], 12'h000} + {22'd0, va[31:22], 2'b00};
    e = u_mem.words[a[13:2]];
    if (!e[pte_v_bit] || (e[pte_w_bit] && !e[pte_r_bit])) return '0;
    if (e[pte_r_bit] || e[pte_x_bit]) begin
      // Megapage, PPN[0] must be clear.
      if (e[19:10] != '0) return '0;
      e[19:10] = va[21:12];
      return e;
    end
    a = {e[31:10], 12'h000} + {22'd0, va[21:12], 2'b00};
    e = u_mem.words[a[13:2]];
    if (!e[pte_v_bit] || (e[pte_w_bit] && !e[pte_r_bit])) return '0;
    if (!e[pte_r_bit] && !e[pte_x_bit]) return '0;
    return e;
  endfunction

  function automatic void reference_result(input logic [31:0] va, input logic wr,
                                           input logic [1:0] mode, input logic [31:0] ms,
                                           input logic [31:0] root,
                                           output logic [33:0] pa, output logic fault);
    logic [1:0] eff;
    logic [31:0] e;
    logic missing;
    eff = ms[mstatus_mprv_bit] ? ms[mstatus_mpp_lsb +: 2] : mode;
    if (eff == priv_machine) begin
      pa = {2'b00, va};
      fault = 1'b0;
      return;
    end
    e = reference_walk(va, root);
    if (ms[mstatus_mxr_bit] && e[pte_x_bit]) e[pte_r_bit] = 1'b1;
    missing = wr ? !e[pte_w_bit] : !e[pte_r_bit];
    if (e[pte_w_bit] && !e[pte_r_bit]) fault = 1'b1;
    else if (eff == priv_supervisor) fault = (e[pte_u_bit] && !ms[mstatus_sum_bit]) || missing;
    else fault = !e[pte_u_bit] || missing;
    pa = fault ? '1 : {e[31:10], va[11:0]};
  endfunction

  // ======================================================================
  // Stimulus helpers.
  // ======================================================================

  task automatic load_page_table();
    for (int i = 0; i < 4096; i++) u_mem.words[i] = '0;
    // Root table, VPN[1] 0 to 4.
    u_mem.words[root_word + 0] = make_pte(22'h2, flag_v);
    u_mem.words[root_word + 1] = make_pte(22'h400, flag_v | flag_r | flag_w);
    u_mem.words[root_word + 2] = make_pte(22'h401, flag_v | flag_r);
    u_mem.words[root_word + 3] = make_pte(22'h5, flag_r | flag_w);
    u_mem.words[root_word + 4] = make_pte(22'h3ffc00, flag_v | flag_r | flag_w | flag_u);
    // Level 0 table in page 2.
    u_mem.words[l0_word + 0] = make_pte(22'h10, flag_v | flag_r | flag_w);
    u_mem.words[l0_word + 1] = make_pte(22'h11, flag_v | flag_r);
    u_mem.words[l0_word + 2] = make_pte(22'h12, flag_v | flag_r | flag_w | flag_u);
    u_mem.words[l0_word + 3] = make_pte(22'h13, flag_v | flag_r | flag_u);
    u_mem.words[l0_word + 4] = make_pte(22'h14, flag_v | flag_w);
    u_mem.words[l0_word + 5] = make_pte(22'h15, flag_v | flag_x);
    u_mem.words[l0_word + 6] = make_pte(22'h16, flag_v);
    u_mem.words[l0_word + 7] = make_pte(22'h17, flag_r | flag_w);
  endtask

  // Starts and ends on a falling edge.
  task automatic run_request(input logic [31:0] va, input logic wr,
                             input logic [1:0] mode, input logic [31:0] ms);
    reference_result(va, wr, mode, ms, satp, exp_pa, exp_fault);
    address = va;
    is_write = wr;
    privilege_mode = mode;
    mstatus = ms;
    valid = 1'b1;
    @(negedge clk);
    while (!ready) @(negedge clk);
    valid = 1'b0;
    @(negedge clk);
    request_count = request_count + 1;
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d requests, %0d errors", name,
             request_count - mark_requests, error_count - mark_errors);
    mark_requests = request_count;
    mark_errors = error_count;
  endtask

  function automatic logic [31:0] mpp_field(input logic [1:0] mode);
    return 32'(mode) << mstatus_mpp_lsb;
  endfunction

  // ======================================================================
  // Tests.
  // ======================================================================

  initial begin
    valid = 1'b0;
    address = '0;
    is_write = 1'b0;
    privilege_mode = priv_machine;
    mstatus = '0;
    satp = satp_root;
    exp_pa = '0;
    exp_fault = 1'b0;
    load_page_table();
    @(negedge clk);
    // Reset drops on a falling edge, so look for it on the rising one.
    while (!resetn) @(posedge clk);
    @(negedge clk);

    run_request(32'h1234_5678, 1'b0, priv_machine, '0);
    run_request(32'hffff_fffc, 1'b1, priv_machine, '0);
    run_request(32'h8000_0000, 1'b0, priv_machine, ms_mprv | mpp_field(priv_machine));
    end_test("machine_mode");

    // Loads and stores act as MPP.
    run_request(32'h0000_0123, 1'b0, priv_machine, ms_mprv | mpp_field(priv_supervisor));
    run_request(32'h0000_0123, 1'b0, priv_machine, ms_mprv | mpp_field(priv_user));
    run_request(32'h0000_2456, 1'b0, priv_machine, ms_mprv | mpp_field(priv_user));
    run_request(32'h0000_1000, 1'b1, priv_machine, ms_mprv | mpp_field(priv_supervisor));
    end_test("mprv");

    run_request(32'h0000_0abc, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_0abc, 1'b1, priv_supervisor, '0);
    run_request(32'h0000_1ffc, 1'b1, priv_supervisor, '0);
    run_request(32'h0000_1004, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_3010, 1'b1, priv_user, '0);
    run_request(32'h0000_3010, 1'b0, priv_user, '0);
    run_request(32'h0000_2010, 1'b1, priv_user, '0);
    // User page from supervisor, SUM clear then set.
    run_request(32'h0000_2010, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_2010, 1'b0, priv_supervisor, ms_sum);
    run_request(32'h0000_0010, 1'b0, priv_user, '0);
    run_request(32'h0000_5000, 1'b0, priv_supervisor, '0);
    end_test("pages_4k");

    run_request(32'h0045_6789, 1'b0, priv_supervisor, '0);
    run_request(32'h0040_0000, 1'b1, priv_supervisor, '0);
    run_request(32'h0080_0010, 1'b0, priv_supervisor, '0);
    // Top PPN bits reach the 34-bit range.
    run_request(32'h0103_4567, 1'b0, priv_user, '0);
    run_request(32'h0103_4567, 1'b1, priv_user, '0);
    end_test("megapages");

    run_request(32'h00c0_0000, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_7000, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_4000, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_4000, 1'b1, priv_supervisor, '0);
    run_request(32'h0000_6000, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_5000, 1'b0, priv_supervisor, '0);
    run_request(32'h0000_5000, 1'b0, priv_supervisor, ms_mxr);
    run_request(32'h0140_0000, 1'b0, priv_supervisor, '0);
    end_test("invalid_and_mxr");

    @(negedge clk);
    $display("Requests %0d, errors %0d", request_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sv32_data_mmu.f
src/riscv_priv_pkg.sv
src/sv32_pkg.sv
src/sv32_translate_data_to_physical.sv
src/sv32_table_walk.sv
src/sv32_data_mmu.sv
test/tb_clock_gen.sv
test/tb_page_table_mem.sv
test/tb_sv32_data_mmu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_sv32_data_mmu
FILELIST  ?= sv32_data_mmu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

# The run passes only if the log holds the pass line.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
